// ==== verilog/burst_consts.svh ====
`ifndef BURST_CONSTS_SVH
`define BURST_CONSTS_SVH

// AXI read-address channel widths
`define BG_ADDR_W      32
`define BG_DATA_W      32
`define BG_STRB_W      (`BG_DATA_W / 8)    // One strobe bit per data byte
`define BG_AXLEN_W     8                   // Beats minus one, up to 256 beats

// Transfer request side
`define BG_LEN_W       16                  // Transfer length in bytes

// Bursts must not cross this boundary
`define BG_PAGE_BYTES  4096

`endif

// ==== verilog/axi_types_pkg.sv ====
`default_nettype none

`include "burst_consts.svh"

// Vectors seen on the AXI read-address channel
package axi_types_pkg;

   typedef logic [`BG_ADDR_W-1:0]  axi_addr_t;   // Byte address
   typedef logic [`BG_AXLEN_W-1:0] axi_len_t;    // Beats minus one
   typedef logic [`BG_STRB_W-1:0]  axi_strb_t;   // Byte lanes of one beat

endpackage

`default_nettype wire

// ==== verilog/xfer_types_pkg.sv ====
`default_nettype none

`include "burst_consts.svh"

// Request side quantities and FSM encodings
package xfer_types_pkg;

   typedef logic [`BG_LEN_W-1:0] xfer_len_t;   // Bytes in one transfer

   // Worst case span is a full length plus a start offset, in beats
   typedef logic [`BG_LEN_W-$clog2(`BG_STRB_W):0] beat_cnt_t;

   typedef enum logic [1:0] {
      REQ_IDLE,
      REQ_BUSY,
      REQ_ACK
   } req_state_t;

   typedef enum logic [1:0] {
      ISS_IDLE,
      ISS_ISSUE,
      ISS_GAP
   } iss_state_t;

endpackage

`default_nettype wire

// ==== verilog/xfer_req_port.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "burst_consts.svh"

module xfer_req_port
   import axi_types_pkg::*;
   import xfer_types_pkg::*;
(
   input  wire             clk_i,
   input  wire             rst_i,
   input  wire             req_i,
   input  wire axi_addr_t  addr_i,
   input  wire xfer_len_t  len_i,
   input  wire             xfer_done_i,    // Last burst went out on the bus
   output logic            ack_o,
   output logic            start_o,
   output axi_addr_t       xfer_addr_o,
   output xfer_len_t       xfer_len_o
);

   req_state_t state_q;
   logic       start_q;
   logic       capture;

   // Only IDLE sees a fresh req_i, since ACK waits for it to drop
   assign capture = (state_q == REQ_IDLE) && req_i;

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         state_q <= REQ_IDLE;
         start_q <= 1'b0;
      end else begin
         start_q <= capture;
         case (state_q)
            REQ_IDLE: if (req_i) state_q <= REQ_BUSY;
            REQ_BUSY: if (xfer_done_i) state_q <= REQ_ACK;
            REQ_ACK:  if (!req_i) state_q <= REQ_IDLE;
            default:  state_q <= REQ_IDLE;
         endcase
      end
   end

   // Request payload, held for the planner until the next capture
   always_ff @(posedge clk_i) begin
      if (capture) begin
         xfer_addr_o <= addr_i;
         xfer_len_o  <= len_i;
      end
   end

   assign ack_o   = (state_q == REQ_ACK);
   assign start_o = start_q;

   a_len_nonzero: assert property (@(posedge clk_i) disable iff (rst_i)
      capture |-> (len_i != '0));

   // Requester must hold req_i until it sees ack_o
   a_req_held: assert property (@(posedge clk_i) disable iff (rst_i)
      (state_q == REQ_BUSY) |-> req_i);

endmodule

`default_nettype wire

// ==== verilog/burst_planner.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "burst_consts.svh"

module burst_planner
   import axi_types_pkg::*;
   import xfer_types_pkg::*;
(
   input  wire             clk_i,
   input  wire             rst_i,
   input  wire             start_i,
   input  wire             burst_accepted_i,
   input  wire axi_addr_t  xfer_addr_i,       // Constant for the whole transfer
   input  wire xfer_len_t  xfer_len_i,
   output axi_addr_t       burst_addr_o,
   output axi_len_t        burst_len_o,
   output logic            last_burst_o,
   output axi_strb_t       first_strb_o,
   output axi_strb_t       last_strb_o,
   output beat_cnt_t       beats_o
);

   localparam int        OFF_W     = $clog2(`BG_STRB_W);
   localparam int        PAGE_W    = $clog2(`BG_PAGE_BYTES);
   localparam int        MAX_BYTES = (1 << `BG_AXLEN_W) * `BG_STRB_W;
   localparam axi_strb_t STRB_ONES = '1;

   typedef logic [PAGE_W:0]    page_cnt_t;   // Byte counts within one page, 4096 included
   typedef logic [`BG_LEN_W:0] span_t;       // Length plus start offset

   // Registered burst state
   axi_addr_t addr_q;                        // Word aligned
   xfer_len_t rem_q;                         // Bytes still to request
   logic      first_q;

   axi_addr_t        cur_addr;
   xfer_len_t        cur_rem;
   logic             cur_first;
   logic [OFF_W-1:0] start_off;
   logic [OFF_W-1:0] cur_off;
   logic [OFF_W-1:0] end_off;
   page_cnt_t        page_bytes;
   page_cnt_t        max_bytes;
   page_cnt_t        lim_bytes;
   xfer_len_t        burst_bytes;
   page_cnt_t        span_bytes;
   page_cnt_t        burst_beats;
   span_t            xfer_span;

   assign start_off = xfer_addr_i[OFF_W-1:0];

   // During start the state is not loaded yet, so plan from the request itself
   assign cur_addr  = start_i ? {xfer_addr_i[`BG_ADDR_W-1:OFF_W], {OFF_W{1'b0}}} : addr_q;
   assign cur_rem   = start_i ? xfer_len_i : rem_q;
   assign cur_first = start_i | first_q;
   assign cur_off   = cur_first ? start_off : '0;

   // Candidate sizes, counted from the first requested byte
   assign page_bytes = page_cnt_t'(`BG_PAGE_BYTES) - page_cnt_t'(cur_addr[PAGE_W-1:0])
                       - page_cnt_t'(cur_off);
   assign max_bytes  = page_cnt_t'(MAX_BYTES) - page_cnt_t'(cur_off);

   always_comb begin
      lim_bytes = (page_bytes < max_bytes) ? page_bytes : max_bytes;
      if (cur_rem < xfer_len_t'(lim_bytes))
         burst_bytes = cur_rem;
      else
         burst_bytes = xfer_len_t'(lim_bytes);
   end

   // Beats are counted from the aligned address
   assign span_bytes  = page_cnt_t'(burst_bytes) + page_cnt_t'(cur_off);
   assign burst_beats = (span_bytes + page_cnt_t'(`BG_STRB_W - 1)) >> OFF_W;

   assign burst_addr_o = cur_addr;
   assign burst_len_o  = axi_len_t'(burst_beats - page_cnt_t'(1));
   assign last_burst_o = (burst_bytes == cur_rem);

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         addr_q  <= '0;
         rem_q   <= '0;
         first_q <= 1'b0;
      end else if (start_i) begin
         addr_q  <= cur_addr;
         rem_q   <= xfer_len_i;
         first_q <= 1'b1;
      end else if (burst_accepted_i) begin
         addr_q  <= cur_addr + (axi_addr_t'(burst_beats) << OFF_W);
         rem_q   <= cur_rem - burst_bytes;
         first_q <= 1'b0;
      end
   end

   // Whole-transfer figures for the data side
   assign xfer_span = span_t'(xfer_len_i) + span_t'(start_off);
   assign end_off   = start_off + xfer_len_i[OFF_W-1:0];   // Wraps within one beat

   always_comb begin
      first_strb_o = STRB_ONES << start_off;
      if (xfer_span < span_t'(`BG_STRB_W))                // Whole transfer in one beat
         first_strb_o = first_strb_o & ~(STRB_ONES << end_off);
      if (end_off == '0)
         last_strb_o = STRB_ONES;
      else
         last_strb_o = ~(STRB_ONES << end_off);
   end

   assign beats_o = beat_cnt_t'((xfer_span + span_t'(`BG_STRB_W - 1)) >> OFF_W);

   // Every burst that goes out ends at or before the page end
   a_no_page_cross: assert property (@(posedge clk_i) disable iff (rst_i)
      burst_accepted_i |->
         (page_cnt_t'(burst_addr_o[PAGE_W-1:0]) + (burst_beats << OFF_W))
            <= page_cnt_t'(`BG_PAGE_BYTES));

endmodule

`default_nettype wire

// ==== verilog/ar_issuer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "burst_consts.svh"

module ar_issuer
   import axi_types_pkg::*;
   import xfer_types_pkg::*;
(
   input  wire             clk_i,
   input  wire             rst_i,
   input  wire             start_i,
   input  wire axi_addr_t  burst_addr_i,
   input  wire axi_len_t   burst_len_i,
   input  wire             last_burst_i,
   input  wire             arready_i,
   output logic            arvalid_o,
   output axi_addr_t       araddr_o,
   output axi_len_t        arlen_o,
   output logic            burst_accepted_o,   // Planner steps to the next burst
   output logic            xfer_done_o
);

   iss_state_t state_q;
   logic       handshake;
   logic       load;

   assign arvalid_o = (state_q == ISS_ISSUE);
   assign handshake = arvalid_o & arready_i;

   // Entry into ISSUE, from a new transfer or after the gap cycle
   assign load = ((state_q == ISS_IDLE) && start_i) || (state_q == ISS_GAP);

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         state_q <= ISS_IDLE;
      end else begin
         case (state_q)
            ISS_IDLE: begin
               if (start_i) state_q <= ISS_ISSUE;
            end
            ISS_ISSUE: begin
               if (handshake) state_q <= last_burst_i ? ISS_IDLE : ISS_GAP;
            end
            ISS_GAP:  state_q <= ISS_ISSUE;   // Planner settles its next burst here
            default:  state_q <= ISS_IDLE;
         endcase
      end
   end

   // Burst fields frozen for the time arvalid_o is high
   always_ff @(posedge clk_i) begin
      if (load) begin
         araddr_o <= burst_addr_i;
         arlen_o  <= burst_len_i;
      end
   end

   assign burst_accepted_o = handshake;
   assign xfer_done_o      = handshake & last_burst_i;

   // AXI rule on a stalled address beat
   a_ar_stable: assert property (@(posedge clk_i) disable iff (rst_i)
      (arvalid_o && !arready_i) |=>
         (arvalid_o && $stable(araddr_o) && $stable(arlen_o)));

endmodule

`default_nettype wire

// ==== verilog/burst_gen_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "burst_consts.svh"

module burst_gen_top
   import axi_types_pkg::*;
   import xfer_types_pkg::*;
(
   input  wire             clk_i,
   input  wire             rst_i,
   input  wire             req_i,
   input  wire axi_addr_t  addr_i,
   input  wire xfer_len_t  len_i,
   input  wire             arready_i,
   output logic            ack_o,
   output logic            arvalid_o,
   output axi_addr_t       araddr_o,
   output axi_len_t        arlen_o,
   output axi_strb_t       first_strb_o,
   output axi_strb_t       last_strb_o,
   output beat_cnt_t       beats_o
);

   logic      start;
   logic      xfer_done;
   logic      burst_accepted;
   logic      last_burst;
   axi_addr_t xfer_addr;
   xfer_len_t xfer_len;
   axi_addr_t burst_addr;
   axi_len_t  burst_len;

   xfer_req_port i_req_port (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .req_i       (req_i),
      .addr_i      (addr_i),
      .len_i       (len_i),
      .xfer_done_i (xfer_done),
      .ack_o       (ack_o),
      .start_o     (start),
      .xfer_addr_o (xfer_addr),
      .xfer_len_o  (xfer_len)
   );

   burst_planner i_planner (
      .clk_i            (clk_i),
      .rst_i            (rst_i),
      .start_i          (start),
      .burst_accepted_i (burst_accepted),
      .xfer_addr_i      (xfer_addr),
      .xfer_len_i       (xfer_len),
      .burst_addr_o     (burst_addr),
      .burst_len_o      (burst_len),
      .last_burst_o     (last_burst),
      .first_strb_o     (first_strb_o),
      .last_strb_o      (last_strb_o),
      .beats_o          (beats_o)
   );

   ar_issuer i_issuer (
      .clk_i            (clk_i),
      .rst_i            (rst_i),
      .start_i          (start),
      .burst_addr_i     (burst_addr),
      .burst_len_i      (burst_len),
      .last_burst_i     (last_burst),
      .arready_i        (arready_i),
      .arvalid_o        (arvalid_o),
      .araddr_o         (araddr_o),
      .arlen_o          (arlen_o),
      .burst_accepted_o (burst_accepted),
      .xfer_done_o      (xfer_done)
   );

endmodule

`default_nettype wire

// ==== test/tb_burst_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "burst_consts.svh"

module tb_burst_gen
   import axi_types_pkg::*;
   import xfer_types_pkg::*;
();

   typedef struct packed {
      axi_addr_t addr;
      int        len;
      axi_strb_t first_strb;
      axi_strb_t last_strb;
      int        beats;
      int        bursts;
   } vector_t;

   // Address, length, first strobe, last strobe, beats, bursts
   vector_t vectors [8] = '{
      '{32'h0000_0100,   16, 4'b1111, 4'b1111,   4, 1},   // Aligned short
      '{32'h0000_0103,   10, 4'b1000, 4'b0001,   4, 1},
      '{32'h0000_0201,    2, 4'b0110, 4'b0111,   1, 1},   // Inside one beat
      '{32'h0000_0FF8,   32, 4'b1111, 4'b1111,   8, 2},   // 4 KB split
      '{32'h0000_0000, 3000, 4'b1111, 4'b1111, 750, 3},   // Length split
      '{32'h0000_0FFE,    4, 4'b1100, 4'b0011,   2, 2},
      '{32'h0000_1F02, 1500, 4'b1100, 4'b0011, 376, 3},   // Page and length split
      '{32'h0000_3001,    1, 4'b0010, 4'b0011,   1, 1}
   };

   logic      clk = 1'b0;
   logic      rst;
   logic      req;
   axi_addr_t addr;
   xfer_len_t len;
   logic      arready;
   logic      ack;
   logic      arvalid;
   axi_addr_t araddr;
   axi_len_t  arlen;
   axi_strb_t first_strb;
   axi_strb_t last_strb;
   beat_cnt_t beats;

   int        errors = 0;
   int        checks = 0;
   int        cycles = 0;
   int        cycle_limit;
   axi_addr_t exp_addr [$];   // Expected bursts of the current transfer
   int        exp_len [$];

   burst_gen_top i_dut (
      .clk_i        (clk),
      .rst_i        (rst),
      .req_i        (req),
      .addr_i       (addr),
      .len_i        (len),
      .arready_i    (arready),
      .ack_o        (ack),
      .arvalid_o    (arvalid),
      .araddr_o     (araddr),
      .arlen_o      (arlen),
      .first_strb_o (first_strb),
      .last_strb_o  (last_strb),
      .beats_o      (beats)
   );

   always #4 clk = ~clk;

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles > cycle_limit) begin
         $display("Timeout, the run did not finish within %0d cycles", cycle_limit);
         $display("Finished with errors");
         $finish;
      end
   end

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      checks = checks + 1;
      if (expected !== actual) begin
         errors = errors + 1;
         $display("[FAIL] %0t %s expected %0h got %0h", $time, name, expected, actual);
      end
   endtask

   // Split a transfer into bursts by page end, 1 KB limit and remaining bytes
   task automatic plan_bursts(input axi_addr_t start_addr, input int length);
      axi_addr_t a;
      int        off;
      int        rem;
      int        page_left;
      int        lim;
      int        bytes;
      int        beat_n;
      exp_addr.delete();
      exp_len.delete();
      a   = start_addr & ~32'h3;
      off = int'(start_addr[1:0]);
      rem = length;
      while (rem > 0) begin
         page_left = `BG_PAGE_BYTES - int'(a[11:0]) - off;
         lim       = (page_left < 1024 - off) ? page_left : 1024 - off;
         bytes     = (rem < lim) ? rem : lim;
         beat_n    = (bytes + off + 3) / 4;   // Counted from the aligned address
         exp_addr.push_back(a);
         exp_len.push_back(beat_n - 1);
         a   = a + 32'(beat_n * 4);
         rem = rem - bytes;
         off = 0;
      end
   endtask

   task automatic run_xfer(input int idx);
      axi_addr_t   prev_addr;
      axi_len_t    prev_len;
      logic [31:0] rnd;
      logic        stall_q;
      logic        hs_q;
      logic        done;
      int          hs_cnt;
      int          cyc;
      plan_bursts(vectors[idx].addr, vectors[idx].len);
      check_value("burst_count", vectors[idx].bursts, exp_addr.size());
      addr    = vectors[idx].addr;
      len     = 16'(vectors[idx].len);
      req     = 1'b1;
      hs_cnt  = 0;
      cyc     = 0;
      stall_q = 1'b0;
      hs_q    = 1'b0;
      done    = 1'b0;
      prev_addr = '0;
      prev_len  = '0;
      while (!done) begin
         @(negedge clk);
         if (cyc == 0) begin   // Request was captured, so scramble the inputs
            rnd  = $urandom;
            addr = rnd;
            len  = 16'hFFFF;
         end
         cyc = cyc + 1;
         if (hs_q)
            check_value("arvalid_o", 32'd0, 32'(arvalid));   // Gap after a handshake
         if (stall_q) begin
            check_value("arvalid_o", 32'd1, 32'(arvalid));
            check_value("araddr_o", prev_addr, araddr);
            check_value("arlen_o", 32'(prev_len), 32'(arlen));
         end
         if (ack) begin
            check_value("handshakes", exp_addr.size(), hs_cnt);
            done = 1'b1;
         end else begin
            rnd     = $urandom;
            arready = rnd[0];
            if (arvalid && arready) begin
               if (hs_cnt < exp_addr.size()) begin
                  check_value("araddr_o", exp_addr[hs_cnt], araddr);
                  check_value("arlen_o", 32'(exp_len[hs_cnt]), 32'(arlen));
               end else begin
                  errors = errors + 1;
                  $display("Burst at %0h was issued beyond the planned count", araddr);
               end
               hs_cnt = hs_cnt + 1;
            end
            stall_q   = arvalid && !arready;
            hs_q      = arvalid && arready;
            prev_addr = araddr;
            prev_len  = arlen;
         end
      end
      // Transfer figures hold while ack is high
      check_value("first_strb_o", 32'(vectors[idx].first_strb), 32'(first_strb));
      check_value("last_strb_o", 32'(vectors[idx].last_strb), 32'(last_strb));
      check_value("beats_o", vectors[idx].beats, 32'(beats));
      req     = 1'b0;
      arready = 1'b0;
      @(negedge clk);
      check_value("ack_o", 32'd0, 32'(ack));
      check_value("arvalid_o", 32'd0, 32'(arvalid));
   endtask

   initial begin
      int total;
      void'($urandom(88));
      rst     = 1'b1;
      req     = 1'b0;
      addr    = '0;
      len     = '0;
      arready = 1'b0;
      total   = 0;
      foreach (vectors[i])
         total = total + vectors[i].bursts;
      cycle_limit = total * 64 + 500;
      repeat (10) @(negedge clk);
      rst = 1'b0;
      @(negedge clk);
      foreach (vectors[i])
         run_xfer(i);
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("Finished with no errors");
      else
         $display("Finished with errors");
      $finish;
   end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+verilog
verilog/axi_types_pkg.sv
verilog/xfer_types_pkg.sv
verilog/xfer_req_port.sv
verilog/burst_planner.sv
verilog/ar_issuer.sv
verilog/burst_gen_top.sv
test/tb_burst_gen.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_burst_gen -f build.f -o tb_burst_gen || exit 1

run_out=$(./obj_dir/tb_burst_gen)
echo "$run_out"

echo "$run_out" | grep -qx "Finished with no errors" && echo "Simulation passed" && exit 0
echo "Simulation failed" && exit 1
